/* Bender.yml */
package:
  name: rv_soc

sources:
  - files:
      - common/rv_pkg.sv
      - core/reg_file.sv
      - core/fetch_unit.sv
      - core/execute_unit.sv
      - core/core_ctrl.sv
      - hdl/host_regs.sv
      - hdl/rv_soc.sv
  - target: test
    files:
      - test/tb_rv_soc.sv

/* common/rv_pkg.sv */
package rv_pkg;

    // widths and memory sizes
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int imem_words = 1024;
    localparam int dmem_words = 1024;
    localparam int imem_aw    = $clog2(imem_words);
    localparam int dmem_aw    = $clog2(dmem_words);

    // host address map, byte offsets on the APB side
    localparam logic [15:0] imem_base   = 16'h0000;
    localparam logic [15:0] addr_ctrl   = 16'h1000;
    localparam logic [15:0] addr_status = 16'h1004;
    localparam logic [15:0] addr_tohost = 16'h1008;

    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_instr  = 32'h0000_0013;
    localparam logic [11:0]     csr_tohost = 12'h51e;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_jal    = 7'b1101111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sll, alu_srl, alu_pass_b
    } alu_op_e;

    typedef enum logic {
        fwd_reg,
        fwd_wb
    } fwd_sel_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_pc4
    } wb_sel_e;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [15:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     use_imm;
        logic     use_pc;
        logic     is_branch;
        logic     branch_ne;
        logic     is_jal;
        logic     mem_write;
        logic     csr_write;
        fwd_sel_e fwd_a;
        fwd_sel_e fwd_b;
    } ex_ctrl_t;

    typedef struct packed {
        logic               valid;
        logic [imem_aw-1:0] idx;
        logic [xlen-1:0]    data;
    } imem_wr_t;

endpackage

/* core/core_ctrl.sv */
`timescale 1ns/1ps

module core_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           run,
    input  logic                           start,
    input  logic [rv_pkg::xlen-1:0]        fetch_instr,
    input  logic [rv_pkg::xlen-1:0]        fetch_pc,
    output logic [rv_pkg::reg_addr_w-1:0]  rs1_addr,
    output logic [rv_pkg::reg_addr_w-1:0]  rs2_addr,
    output logic [rv_pkg::xlen-1:0]        ex_instr,
    output logic [rv_pkg::xlen-1:0]        ex_pc,
    output rv_pkg::ex_ctrl_t               ex_ctrl,
    output rv_pkg::fwd_sel_e               fwd_a,
    output rv_pkg::fwd_sel_e               fwd_b,
    input  logic                           branch_taken,
    input  logic [rv_pkg::xlen-1:0]        alu_result,
    input  logic [rv_pkg::xlen-1:0]        load_data,
    input  logic [rv_pkg::xlen-1:0]        csr_value,
    output logic                           redirect,
    output logic [rv_pkg::xlen-1:0]        target,
    output logic                           rf_we,
    output logic [rv_pkg::reg_addr_w-1:0]  rf_waddr,
    output logic [rv_pkg::xlen-1:0]        rf_wdata,
    output logic                           tohost_we,
    output logic [rv_pkg::xlen-1:0]        tohost_data
);
    import rv_pkg::*;

    logic [xlen-1:0]       dec_instr;
    logic [reg_addr_w-1:0] dec_rd;
    ex_ctrl_t              dec_ctrl;
    logic                  dec_rd_we;
    wb_sel_e               dec_wb_sel;
    logic                  squash;

    ex_ctrl_t              ex_ctrl_q;
    logic [xlen-1:0]       ex_instr_q;
    logic [xlen-1:0]       ex_pc_q;
    logic                  ex_rd_we_q;
    wb_sel_e               ex_wb_sel_q;

    logic                  wb_rd_we_q;
    logic [reg_addr_w-1:0] wb_rd_q;
    wb_sel_e               wb_sel_q;
    logic [xlen-1:0]       wb_alu_q;
    logic [xlen-1:0]       wb_pc4_q;

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b100:  return alu_xor;
            3'b101:  return alu_srl;
            3'b110:  return alu_or;
            3'b111:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    // kill the word in decode when stopped, restarting or leaving on a jump
    assign squash    = !run || start || branch_taken;
    assign dec_instr = squash ? nop_instr : fetch_instr;
    assign dec_rd    = dec_instr[11:7];
    assign rs1_addr  = dec_instr[19:15];
    assign rs2_addr  = dec_instr[24:20];

    always_comb begin
        dec_ctrl   = '0;
        dec_rd_we  = 1'b0;
        dec_wb_sel = wb_alu;
        case (opcode_e'(dec_instr[6:0]))
            opc_op: begin
                dec_ctrl.alu_op = alu_decode(dec_instr[14:12], dec_instr[30]);
                dec_rd_we       = 1'b1;
            end
            opc_op_imm: begin
                dec_ctrl.alu_op  = alu_decode(dec_instr[14:12], 1'b0);
                dec_ctrl.use_imm = 1'b1;
                dec_rd_we        = 1'b1;
            end
            opc_lui: begin
                dec_ctrl.alu_op  = alu_pass_b;
                dec_ctrl.use_imm = 1'b1;
                dec_rd_we        = 1'b1;
            end
            opc_jal: begin
                dec_ctrl.use_pc  = 1'b1;
                dec_ctrl.use_imm = 1'b1;
                dec_ctrl.is_jal  = 1'b1;
                dec_wb_sel       = wb_pc4;
                dec_rd_we        = 1'b1;
            end
            opc_branch: begin
                dec_ctrl.use_pc    = 1'b1;
                dec_ctrl.use_imm   = 1'b1;
                dec_ctrl.is_branch = 1'b1;
                dec_ctrl.branch_ne = dec_instr[12];
            end
            opc_load: begin
                dec_ctrl.use_imm = 1'b1;
                dec_wb_sel       = wb_load;
                dec_rd_we        = 1'b1;
            end
            opc_store: begin
                dec_ctrl.use_imm   = 1'b1;
                dec_ctrl.mem_write = 1'b1;
            end
            opc_system: begin
                dec_ctrl.csr_write = (dec_instr[14:12] == 3'b001) &&
                                     (dec_instr[31:20] == csr_tohost);
            end
            default: begin
                dec_rd_we = 1'b0;
            end
        endcase
        if (dec_rd == '0) begin
            dec_rd_we = 1'b0;
        end
        // producer now in execute will sit in writeback next cycle
        if (ex_rd_we_q && ex_instr_q[11:7] == rs1_addr) begin
            dec_ctrl.fwd_a = fwd_wb;
        end
        if (ex_rd_we_q && ex_instr_q[11:7] == rs2_addr) begin
            dec_ctrl.fwd_b = fwd_wb;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_ctrl_q   <= '0;
            ex_instr_q  <= nop_instr;
            ex_pc_q     <= '0;
            ex_rd_we_q  <= 1'b0;
            ex_wb_sel_q <= wb_alu;
            wb_rd_we_q  <= 1'b0;
            wb_rd_q     <= '0;
            wb_sel_q    <= wb_alu;
        end else begin
            ex_ctrl_q   <= dec_ctrl;
            ex_instr_q  <= dec_instr;
            ex_pc_q     <= fetch_pc;
            ex_rd_we_q  <= dec_rd_we;
            ex_wb_sel_q <= dec_wb_sel;
            wb_rd_we_q  <= ex_rd_we_q;
            wb_rd_q     <= ex_instr_q[11:7];
            wb_sel_q    <= ex_wb_sel_q;
        end
    end

    // writeback payload
    always_ff @(posedge clk) begin
        wb_alu_q <= alu_result;
        wb_pc4_q <= ex_pc_q + xlen'(4);
    end

    assign ex_instr = ex_instr_q;
    assign ex_pc    = ex_pc_q;
    assign ex_ctrl  = ex_ctrl_q;

    assign fwd_a = (wb_rd_we_q && wb_rd_q == ex_instr_q[19:15]) ? fwd_wb : fwd_reg;
    assign fwd_b = (wb_rd_we_q && wb_rd_q == ex_instr_q[24:20]) ? fwd_wb : fwd_reg;

    // jal and branch targets come out of the ALU as pc + imm
    assign redirect = branch_taken;
    assign target   = alu_result;

    assign rf_we    = wb_rd_we_q;
    assign rf_waddr = wb_rd_q;
    always_comb begin
        case (wb_sel_q)
            wb_load: rf_wdata = load_data;
            wb_pc4:  rf_wdata = wb_pc4_q;
            default: rf_wdata = wb_alu_q;
        endcase
    end

    assign tohost_we   = ex_ctrl_q.csr_write;
    assign tohost_data = csr_value;

    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        rf_we |-> rf_waddr != '0);

endmodule

/* core/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [rv_pkg::xlen-1:0] instr,
    input  logic [rv_pkg::xlen-1:0] pc,
    input  rv_pkg::ex_ctrl_t        ctrl,
    input  rv_pkg::fwd_sel_e        fwd_a,
    input  rv_pkg::fwd_sel_e        fwd_b,
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    input  logic [rv_pkg::xlen-1:0] wb_data,
    output logic [rv_pkg::xlen-1:0] alu_result,
    output logic                    branch_taken,
    output logic [rv_pkg::xlen-1:0] load_data,
    output logic [rv_pkg::xlen-1:0] csr_value
);
    import rv_pkg::*;

    logic [xlen-1:0] dmem [dmem_words];
    logic [xlen-1:0] rs1_q;
    logic [xlen-1:0] rs2_q;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] load_q;
    logic [dmem_aw-1:0] dmem_idx;

    // operands were read in decode
    always_ff @(posedge clk) begin
        rs1_q <= rs1_data;
        rs2_q <= rs2_data;
    end

    assign rs1_val = (fwd_a == fwd_wb) ? wb_data : rs1_q;
    assign rs2_val = (fwd_b == fwd_wb) ? wb_data : rs2_q;

    always_comb begin
        case (opcode_e'(instr[6:0]))
            opc_op_imm, opc_load: imm = {{20{instr[31]}}, instr[31:20]};
            opc_store:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            opc_branch: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            opc_lui:    imm = {instr[31:12], 12'b0};
            opc_jal:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:    imm = '0;
        endcase
    end

    assign op_a = ctrl.use_pc ? pc : rs1_val;
    assign op_b = ctrl.use_imm ? imm : rs2_val;

    always_comb begin
        case (ctrl.alu_op)
            alu_sub:    alu_result = op_a - op_b;
            alu_and:    alu_result = op_a & op_b;
            alu_or:     alu_result = op_a | op_b;
            alu_xor:    alu_result = op_a ^ op_b;
            alu_slt:    alu_result = xlen'($signed(op_a) < $signed(op_b));
            alu_sll:    alu_result = op_a << op_b[4:0];
            alu_srl:    alu_result = op_a >> op_b[4:0];
            alu_pass_b: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    // beq/bne share one compare, funct3 bit 0 flips it
    assign branch_taken = ctrl.is_jal ||
                          (ctrl.is_branch && ((rs1_val == rs2_val) != ctrl.branch_ne));

    assign csr_value = rs1_val;

    // word addressed data memory, load data lands in writeback
    assign dmem_idx = alu_result[dmem_aw+1:2];
    always_ff @(posedge clk) begin
        if (ctrl.mem_write) begin
            dmem[dmem_idx] <= rs2_val;
        end
        load_q <= dmem[dmem_idx];
    end

    assign load_data = load_q;

    // only word stores exist, low address bits must be zero
    a_store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.mem_write |-> alu_result[1:0] == 2'b00);

endmodule

/* core/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    run,
    input  logic                    start,
    input  rv_pkg::imem_wr_t        imem_wr,
    input  logic                    redirect,
    input  logic [rv_pkg::xlen-1:0] target,
    output logic [rv_pkg::xlen-1:0] instr,
    output logic [rv_pkg::xlen-1:0] pc
);
    import rv_pkg::*;

    logic [xlen-1:0] imem [imem_words];
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] instr_q;

    always_comb begin
        if (start) begin
            next_pc = '0;
        end else if (redirect) begin
            next_pc = target;
        end else if (run) begin
            next_pc = pc_q + xlen'(4);
        end else begin
            next_pc = pc_q;
        end
    end

    // host loads the program through the write port
    always_ff @(posedge clk) begin
        if (imem_wr.valid) begin
            imem[imem_wr.idx] <= imem_wr.data;
        end
    end

    // synchronous read, word lines up with pc_q a cycle later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q    <= '0;
            instr_q <= nop_instr;
        end else begin
            pc_q    <= next_pc;
            instr_q <= imem[next_pc[imem_aw+1:2]];
        end
    end

    assign pc    = pc_q;
    assign instr = instr_q;

    a_no_load_while_run: assert property (@(posedge clk) disable iff (!rst_n)
        imem_wr.valid |-> !run);

endmodule

/* core/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::reg_addr_w-1:0] ra1,
    input  logic [rv_pkg::reg_addr_w-1:0] ra2,
    output logic [rv_pkg::xlen-1:0]       rd1,
    output logic [rv_pkg::xlen-1:0]       rd2,
    input  logic                          we,
    input  logic [rv_pkg::reg_addr_w-1:0] wa,
    input  logic [rv_pkg::xlen-1:0]       wd
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];

    // no writes land while held in reset
    always_ff @(posedge clk) begin
        if (rst_n && we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // x0 reads zero, a same cycle write goes straight through
    always_comb begin
        if (ra1 == '0) begin
            rd1 = '0;
        end else if (we && wa == ra1) begin
            rd1 = wd;
        end else begin
            rd1 = regs[ra1];
        end
        if (ra2 == '0) begin
            rd2 = '0;
        end else if (we && wa == ra2) begin
            rd2 = wd;
        end else begin
            rd2 = regs[ra2];
        end
    end

endmodule

/* filelist.f */
common/rv_pkg.sv
core/reg_file.sv
core/fetch_unit.sv
core/execute_unit.sv
core/core_ctrl.sv
hdl/host_regs.sv
hdl/rv_soc.sv
test/tb_rv_soc.sv

/* hdl/host_regs.sv */
`timescale 1ns/1ps

module host_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_pkg::apb_req_t        apb_req,
    output rv_pkg::apb_rsp_t        apb_rsp,
    output rv_pkg::imem_wr_t        imem_wr,
    output logic                    run,
    output logic                    start,
    input  logic                    tohost_we,
    input  logic [rv_pkg::xlen-1:0] tohost_data
);
    import rv_pkg::*;

    logic            access;
    logic            is_imem;
    logic            is_ctrl;
    logic            is_status;
    logic            is_tohost;
    logic            slv_err;
    logic            ctrl_wr;
    logic            run_q;
    logic            done_q;
    logic            start_q;
    logic [xlen-1:0] tohost_q;
    logic [15:0]     imem_off;

    assign access    = apb_req.psel && apb_req.penable;
    assign imem_off  = apb_req.paddr - imem_base;
    assign is_imem   = imem_off < (addr_ctrl - imem_base);
    assign is_ctrl   = apb_req.paddr == addr_ctrl;
    assign is_status = apb_req.paddr == addr_status;
    assign is_tohost = apb_req.paddr == addr_tohost;

    // unmapped, program load while running, or write to a read-only register
    assign slv_err = !(is_imem || is_ctrl || is_status || is_tohost) ||
                     (apb_req.pwrite && is_imem && run_q) ||
                     (apb_req.pwrite && (is_status || is_tohost));

    assign ctrl_wr = access && apb_req.pwrite && is_ctrl;

    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && slv_err;
        if (is_ctrl) begin
            apb_rsp.prdata = {31'b0, run_q};
        end else if (is_status) begin
            apb_rsp.prdata = {31'b0, done_q};
        end else if (is_tohost) begin
            apb_rsp.prdata = tohost_q;
        end else begin
            apb_rsp.prdata = '0;
        end
    end

    assign imem_wr.valid = access && apb_req.pwrite && is_imem && !run_q;
    assign imem_wr.idx   = imem_off[imem_aw+1:2];
    assign imem_wr.data  = apb_req.pwdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q    <= 1'b0;
            done_q   <= 1'b0;
            start_q  <= 1'b0;
            tohost_q <= '0;
        end else begin
            start_q <= 1'b0;
            if (ctrl_wr && apb_req.pwdata[0] && !run_q) begin
                run_q    <= 1'b1;
                start_q  <= 1'b1;
                done_q   <= 1'b0;
                tohost_q <= '0;
            end else if (ctrl_wr && !apb_req.pwdata[0]) begin
                run_q <= 1'b0;
            end
            // program finished
            if (tohost_we) begin
                tohost_q <= tohost_data;
                done_q   <= 1'b1;
                run_q    <= 1'b0;
            end
        end
    end

    assign run   = run_q;
    assign start = start_q;

    a_penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
        apb_req.penable |-> apb_req.psel);

endmodule

/* hdl/rv_soc.sv */
`timescale 1ns/1ps

module rv_soc (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::apb_req_t apb_req,
    output rv_pkg::apb_rsp_t apb_rsp
);
    import rv_pkg::*;

    imem_wr_t              imem_wr;
    logic                  run;
    logic                  start;
    logic                  tohost_we;
    logic [xlen-1:0]       tohost_data;
    logic [xlen-1:0]       fetch_instr;
    logic [xlen-1:0]       fetch_pc;
    logic                  redirect;
    logic [xlen-1:0]       target;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic [xlen-1:0]       ex_instr;
    logic [xlen-1:0]       ex_pc;
    ex_ctrl_t              ex_ctrl;
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;
    logic                  branch_taken;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       load_data;
    logic [xlen-1:0]       csr_value;
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;

    host_regs u_host_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .imem_wr     (imem_wr),
        .run         (run),
        .start       (start),
        .tohost_we   (tohost_we),
        .tohost_data (tohost_data)
    );

    core_ctrl u_core_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .start        (start),
        .fetch_instr  (fetch_instr),
        .fetch_pc     (fetch_pc),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .ex_instr     (ex_instr),
        .ex_pc        (ex_pc),
        .ex_ctrl      (ex_ctrl),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .branch_taken (branch_taken),
        .alu_result   (alu_result),
        .load_data    (load_data),
        .csr_value    (csr_value),
        .redirect     (redirect),
        .target       (target),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .tohost_we    (tohost_we),
        .tohost_data  (tohost_data)
    );

    fetch_unit u_fetch_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),
        .start    (start),
        .imem_wr  (imem_wr),
        .redirect (redirect),
        .target   (target),
        .instr    (fetch_instr),
        .pc       (fetch_pc)
    );

    execute_unit u_execute_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (ex_instr),
        .pc           (ex_pc),
        .ctrl         (ex_ctrl),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .wb_data      (rf_wdata),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .load_data    (load_data),
        .csr_value    (csr_value)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (rs1_addr),
        .ra2   (rs2_addr),
        .rd1   (rs1_data),
        .rd2   (rs2_data),
        .we    (rf_we),
        .wa    (rf_waddr),
        .wd    (rf_wdata)
    );

endmodule

/* test/program_golden.txt */
// per test: test id, word count, instruction words, expected tohost value
// a test id of 0 ends the list
// alu ops and immediates, each using the result just before it
00000001 00000015
00500093 00308113 002081B3 40118233 00421293 0032E333
0FF34393 03C3F413 0022D493 00922533 00A315B3 00A5D633
008646B3 0076F733 FFF72793 1007E813 00E808B3 FFE88913
40D909B3 51E99073 00000013
00000071
// lui built address and data, three sw, lw results used at once
00000002 0000000F
000010B7 12345137 67810113 0020A023 ABCDE1B7 0030A223
05500213 0040A423 0000A283 0040A303 006283B3 0080A403
008384B3 51E49073 00000013
BE0236CD
// beq and bne both ways, jal link into x5, squashed increments of x10
00000003 00000011
00100093 00100113 00000513 00208463 00150513 00209463
00700193 00309463 00150513 00308463 008002EF 00150513
01051313 005303B3 003383B3 51E39073 00000013
00000033
// end of list
00000000

/* test/tb_rv_soc.sv */
`timescale 1ns/1ps

module tb_rv_soc;
    import rv_pkg::*;

    localparam int golden_depth = 256;

    logic        clk;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;

    logic [31:0] golden [golden_depth];
    logic [31:0] prog_buf [64];
    int          prog_len;
    string       cur_test;
    int          cycles = 0;
    int          cycle_limit = 32'h7fff_ffff;

    rv_soc dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_eq(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch in %s (%s): expected %h, actual %h",
                               cur_test, what, expected, actual));
        end
    endtask

    // limit is set from the golden file before the first edge
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            fail_run($sformatf("timeout: the program did not finish within %0d cycles",
                               cycle_limit));
        end
    end

    // called on a falling edge, setup now and access one cycle later
    task automatic apb_write(input logic [15:0] addr, input logic [31:0] data,
                             output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #2;
        check_eq("pready on write", 32'h1, {31'b0, apb_rsp.pready});
        err = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [15:0] addr, output logic [31:0] data,
                            output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwdata  = '0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #2;
        check_eq("pready on read", 32'h1, {31'b0, apb_rsp.pready});
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    // load prog_buf, start the core, wait for done, check tohost
    task automatic run_program(input logic [31:0] expected, input bit probe_run);
        logic        err;
        logic [31:0] data;
        logic [15:0] addr;
        int          i;
        for (i = 0; i < prog_len; i++) begin
            addr = imem_base + i * 4;
            apb_write(addr, prog_buf[i], err);
            check_eq("pslverr on program load", 32'h0, {31'b0, err});
        end
        apb_write(addr_ctrl, 32'h1, err);
        check_eq("pslverr on run write", 32'h0, {31'b0, err});
        apb_read(addr_status, data, err);
        check_eq("done cleared by start", 32'h0, data);
        apb_read(addr_ctrl, data, err);
        check_eq("run while busy", 32'h1, data);
        if (probe_run) begin
            apb_write(16'h0ffc, 32'h0, err);
            check_eq("pslverr on imem write while running", 32'h1, {31'b0, err});
        end
        data = '0;
        while (data == 32'h0) begin
            apb_read(addr_status, data, err);
        end
        check_eq("status after done", 32'h1, data);
        apb_read(addr_ctrl, data, err);
        check_eq("run after done", 32'h0, data);
        apb_read(addr_tohost, data, err);
        check_eq("tohost", expected, data);
    endtask

    function automatic string test_name(input logic [31:0] id);
        case (id)
            32'd1:   test_name = "alu_forwarding";
            32'd2:   test_name = "memory_lui";
            32'd3:   test_name = "control_flow";
            default: test_name = $sformatf("test_%0d", id);
        endcase
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        enc_i = {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        enc_r = {7'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        sext12 = {{20{v[11]}}, v};
    endfunction

    initial begin
        int          ptr;
        int          n;
        int          i;
        int          num_tests;
        int          total_words;
        logic        err;
        logic [31:0] data;
        logic [31:0] r_a;
        logic [31:0] r_b;
        logic [31:0] r_c;
        logic [31:0] r_u;
        logic [31:0] r_d;
        logic [31:0] exp_rand;

        void'($urandom(32'h21a));
        rst_n    = 1'b0;
        apb_req  = '0;
        for (ptr = 0; ptr < golden_depth; ptr++) begin
            golden[ptr] = '0;
        end
        $readmemh("test/program_golden.txt", golden);

        // the generated x0 program adds one test of 10 words
        ptr         = 0;
        num_tests   = 1;
        total_words = 10;
        while (ptr < golden_depth - 2 && golden[ptr] != 32'h0) begin
            total_words += golden[ptr + 1];
            num_tests++;
            ptr += golden[ptr + 1] + 3;
        end
        if (num_tests == 1) begin
            fail_run("the golden file holds no tests");
        end
        cycle_limit = 20 * total_words + 200 * num_tests;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        cur_test = "host_protocol";
        apb_write(16'h2000, 32'h0, err);
        check_eq("pslverr on unmapped write", 32'h1, {31'b0, err});
        apb_read(16'h1010, data, err);
        check_eq("pslverr on unmapped read", 32'h1, {31'b0, err});
        apb_write(addr_status, 32'h1, err);
        check_eq("pslverr on status write", 32'h1, {31'b0, err});
        apb_write(addr_tohost, 32'h1, err);
        check_eq("pslverr on tohost write", 32'h1, {31'b0, err});
        apb_read(addr_status, data, err);
        check_eq("done after reset", 32'h0, data);

        // every program after the first one is a restart
        ptr = 0;
        while (golden[ptr] != 32'h0) begin
            n        = golden[ptr + 1];
            cur_test = test_name(golden[ptr]);
            prog_len = n;
            for (i = 0; i < n; i++) begin
                prog_buf[i] = golden[ptr + 2 + i];
            end
            run_program(golden[ptr + 2 + n], ptr == 0);
            ptr += n + 3;
        end

        // x0 writes and same-cycle register reads
        cur_test = "x0_write_through";
        r_a = $urandom;
        r_b = $urandom;
        r_c = $urandom;
        r_u = $urandom;
        r_d = $urandom;
        prog_buf[0] = enc_i(r_a[11:0], 5'd0, 3'b000, 5'd0, 7'b0010011);
        prog_buf[1] = enc_i(r_b[11:0], 5'd0, 3'b000, 5'd1, 7'b0010011);
        prog_buf[2] = enc_i(r_c[11:0], 5'd1, 3'b000, 5'd2, 7'b0010011);
        prog_buf[3] = {r_u[31:12], 5'd0, 7'b0110111};
        prog_buf[4] = enc_r(5'd0, 5'd2, 3'b000, 5'd3);
        prog_buf[5] = enc_i(r_d[11:0], 5'd3, 3'b000, 5'd0, 7'b0010011);
        prog_buf[6] = enc_r(5'd0, 5'd3, 3'b100, 5'd4);
        prog_buf[7] = enc_r(5'd1, 5'd4, 3'b000, 5'd5);
        prog_buf[8] = enc_i(12'h51e, 5'd5, 3'b001, 5'd0, 7'b1110011);
        prog_buf[9] = 32'h0000_0013;
        prog_len    = 10;
        // x1 = b, x2 = b + c, x3 = x4 = x2, x5 = x4 + x1
        exp_rand = sext12(r_b[11:0]) + sext12(r_c[11:0]) + sext12(r_b[11:0]);
        run_program(exp_rand, 1'b0);

        $display("Simulation PASSED");
        $finish;
    end

endmodule
